/* hdl/cache_pkg.sv */
// command codes, address, line and result structs, cache geometry constants
`default_nettype none

package cache_pkg;

    localparam int SETS     = 16;
    localparam int INDEX_W  = $clog2(SETS);
    localparam int TAG_W    = 22;
    localparam int OFFSET_W = 32 - TAG_W - INDEX_W;  // 64-byte lines
    localparam int LRU_W    = 3;
    localparam int MAX_WAYS = 8;
    localparam int WAY_W    = $clog2(MAX_WAYS);

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [LRU_W-1:0] lru_t;  // 0 is most recently used
    typedef logic [WAY_W-1:0] way_t;

    typedef enum logic [3:0] {
        READ_D     = 4'd0,
        WRITE_D    = 4'd1,
        FETCH_I    = 4'd2,
        INVALIDATE = 4'd3,  // from L2
        SNOOP      = 4'd4,
        CLEAR      = 4'd8,
        NOP        = 4'd9
    } cmd_code_t;

    typedef struct packed {
        tag_t                tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } address_t;

    typedef struct packed {
        cmd_code_t n;
        address_t  address;
    } command_t;

    typedef struct packed {
        logic valid;
        lru_t lru;
        tag_t tag;
    } cache_line_t;

    typedef struct packed {
        cmd_code_t code;
        logic      hit;
        way_t      way;
        logic      evict;      // a miss displaced a valid line
        tag_t      evict_tag;
        logic      icache;     // instruction cache was used
        logic      changed;    // store gets written
    } result_t;

endpackage

`default_nettype wire

/* hdl/cache_set_store.sv */
// set-indexed storage for the data and instruction cache lines
`timescale 1ns/10ps
`default_nettype none

module cache_set_store #(
    parameter int D_WAYS = 8,
    parameter int I_WAYS = 4
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic [cache_pkg::INDEX_W-1:0] index_i,
    input  logic                          clear_i,
    input  logic                          d_we_i,
    input  logic                          i_we_i,
    input  cache_pkg::cache_line_t        d_lines_i [D_WAYS],
    input  cache_pkg::cache_line_t        i_lines_i [I_WAYS],
    output cache_pkg::cache_line_t        d_lines_o [D_WAYS],
    output cache_pkg::cache_line_t        i_lines_o [I_WAYS]
);

    cache_pkg::cache_line_t d_mem [cache_pkg::SETS][D_WAYS];
    cache_pkg::cache_line_t i_mem [cache_pkg::SETS][I_WAYS];

    // invalid line, aged by its way number so the LRU order stays a permutation
    function automatic cache_pkg::cache_line_t fresh_line(input int way);
        cache_pkg::cache_line_t line;
        line     = '0;
        line.lru = cache_pkg::lru_t'(way);
        return line;
    endfunction

    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                for (int w = 0; w < D_WAYS; w++) begin
                    d_mem[s][w] <= fresh_line(w);
                end
                for (int w = 0; w < I_WAYS; w++) begin
                    i_mem[s][w] <= fresh_line(w);
                end
            end
        end else begin
            // a write always replaces the whole set
            if (d_we_i) begin
                for (int w = 0; w < D_WAYS; w++) begin
                    d_mem[index_i][w] <= d_lines_i[w];
                end
            end
            if (i_we_i) begin
                for (int w = 0; w < I_WAYS; w++) begin
                    i_mem[index_i][w] <= i_lines_i[w];
                end
            end
        end
    end

    // addressed set is read without a clock
    always_comb begin
        for (int w = 0; w < D_WAYS; w++) begin
            d_lines_o[w] = d_mem[index_i][w];
        end
        for (int w = 0; w < I_WAYS; w++) begin
            i_lines_o[w] = i_mem[index_i][w];
        end
    end

endmodule

`default_nettype wire

/* hdl/way_lookup.sv */
// tag compare over the ways of one cache, hit encode and victim choice
`timescale 1ns/10ps
`default_nettype none

module way_lookup #(
    parameter int WAYS = 8
) (
    input  cache_pkg::tag_t        tag_i,
    input  cache_pkg::cache_line_t lines_i [WAYS],
    output logic                   hit_o,
    output cache_pkg::way_t        way_o,
    output logic                   victim_valid_o
);

    localparam int SEL_W = $clog2(WAYS);

    logic [WAYS-1:0] match;
    logic [WAYS-1:0] free;
    cache_pkg::way_t hit_way;
    cache_pkg::way_t free_way;
    cache_pkg::way_t old_way;

    always_comb begin : compare
        for (int w = 0; w < WAYS; w++) begin
            match[w] = lines_i[w].valid && (lines_i[w].tag == tag_i);  // stale tags never hit
            free[w]  = !lines_i[w].valid;
        end
    end

    // walk downwards so the lowest numbered way wins
    always_comb begin : encode
        hit_way  = '0;
        free_way = '0;
        old_way  = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
            if (free[w]) begin
                free_way = cache_pkg::way_t'(w);
            end
            if (lines_i[w].lru == cache_pkg::lru_t'(WAYS - 1)) begin
                old_way = cache_pkg::way_t'(w);  // least recently used
            end
        end
    end

    assign hit_o = |match;

    always_comb begin : choose
        if (hit_o) begin
            way_o = hit_way;
        end else if (|free) begin
            way_o = free_way;
        end else begin
            way_o = old_way;
        end
    end

    assign victim_valid_o = lines_i[way_o[SEL_W-1:0]].valid;

endmodule

`default_nettype wire

/* hdl/lru_update.sv */
// next-state lines of one cache set: aging, install and invalidate
`timescale 1ns/10ps
`default_nettype none

module lru_update #(
    parameter int WAYS = 8
) (
    input  cache_pkg::cmd_code_t   code_i,
    input  cache_pkg::tag_t        tag_i,
    input  logic                   hit_i,
    input  cache_pkg::way_t        way_i,
    input  cache_pkg::cache_line_t lines_i [WAYS],
    output cache_pkg::cache_line_t lines_o [WAYS],
    output logic                   changed_o
);

    localparam int SEL_W = $clog2(WAYS);

    logic [SEL_W-1:0]       sel;
    cache_pkg::cache_line_t chosen;

    assign sel    = way_i[SEL_W-1:0];
    assign chosen = lines_i[sel];

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            lines_o[w] = lines_i[w];
        end
        changed_o = 1'b0;

        case (code_i)
            cache_pkg::READ_D,
            cache_pkg::WRITE_D,
            cache_pkg::FETCH_I: begin
                // lines younger than the chosen one age by one
                for (int w = 0; w < WAYS; w++) begin
                    if (lines_i[w].lru < chosen.lru) begin
                        lines_o[w].lru = lines_i[w].lru + 1'b1;
                    end
                end
                lines_o[sel].valid = 1'b1;
                lines_o[sel].lru   = '0;     // now most recent
                lines_o[sel].tag   = tag_i;
                changed_o          = 1'b1;
            end
            cache_pkg::INVALIDATE: begin
                if (hit_i) begin
                    lines_o[sel].valid = 1'b0;  // age kept as it was
                    changed_o          = 1'b1;
                end
            end
            default: begin
                // snoop and the rest leave the set alone
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/processor.sv */
// command processor: cache routing, lookup and update for both caches, result
`timescale 1ns/10ps
`default_nettype none

module processor #(
    parameter int D_WAYS = 8,
    parameter int I_WAYS = 4
) (
    input  cache_pkg::command_t    instruction_i,
    input  logic                   cmd_pending_i,
    input  cache_pkg::cache_line_t current_line_d_i [D_WAYS],
    input  cache_pkg::cache_line_t current_line_i_i [I_WAYS],
    output cache_pkg::cache_line_t return_line_d_o [D_WAYS],
    output cache_pkg::cache_line_t return_line_i_o [I_WAYS],
    output logic                   d_we_o,
    output logic                   i_we_o,
    output logic                   clear_o,
    output cache_pkg::result_t     result_o
);

    localparam int D_SEL_W = $clog2(D_WAYS);
    localparam int I_SEL_W = $clog2(I_WAYS);

    logic            use_d;
    logic            use_i;
    logic            d_fill;  // data miss installs a line
    logic            d_hit;
    logic            i_hit;
    logic            d_victim_valid;
    logic            i_victim_valid;
    logic            d_changed;
    logic            i_changed;
    logic            evict;
    cache_pkg::way_t d_way;
    cache_pkg::way_t i_way;

    always_comb begin : route
        use_d  = 1'b0;
        use_i  = 1'b0;
        d_fill = 1'b0;
        case (instruction_i.n)
            cache_pkg::READ_D, cache_pkg::WRITE_D: begin
                use_d  = 1'b1;
                d_fill = 1'b1;
            end
            cache_pkg::INVALIDATE, cache_pkg::SNOOP: use_d = 1'b1;
            cache_pkg::FETCH_I:                      use_i = 1'b1;
            default:                                 use_d = 1'b0;  // clear, nop, unknown
        endcase
    end

    way_lookup #(.WAYS(D_WAYS)) u_d_lookup (
        .tag_i          (instruction_i.address.tag),
        .lines_i        (current_line_d_i),
        .hit_o          (d_hit),
        .way_o          (d_way),
        .victim_valid_o (d_victim_valid)
    );

    way_lookup #(.WAYS(I_WAYS)) u_i_lookup (
        .tag_i          (instruction_i.address.tag),
        .lines_i        (current_line_i_i),
        .hit_o          (i_hit),
        .way_o          (i_way),
        .victim_valid_o (i_victim_valid)
    );

    lru_update #(.WAYS(D_WAYS)) u_d_update (
        .code_i    (instruction_i.n),
        .tag_i     (instruction_i.address.tag),
        .hit_i     (d_hit),
        .way_i     (d_way),
        .lines_i   (current_line_d_i),
        .lines_o   (return_line_d_o),
        .changed_o (d_changed)
    );

    lru_update #(.WAYS(I_WAYS)) u_i_update (
        .code_i    (instruction_i.n),
        .tag_i     (instruction_i.address.tag),
        .hit_i     (i_hit),
        .way_i     (i_way),
        .lines_i   (current_line_i_i),
        .lines_o   (return_line_i_o),
        .changed_o (i_changed)
    );

    // only the selected cache may write, and only for a live command
    assign d_we_o  = cmd_pending_i && use_d && d_changed;
    assign i_we_o  = cmd_pending_i && use_i && i_changed;
    assign clear_o = cmd_pending_i && (instruction_i.n == cache_pkg::CLEAR);

    assign evict = use_i ? (!i_hit && i_victim_valid) : (d_fill && !d_hit && d_victim_valid);

    always_comb begin : form_result
        result_o       = '0;
        result_o.code  = instruction_i.n;
        result_o.evict = evict;
        if (use_i) begin
            result_o.icache  = 1'b1;
            result_o.hit     = i_hit;
            result_o.way     = i_way;
            result_o.changed = i_changed;
            if (evict) begin
                result_o.evict_tag = current_line_i_i[i_way[I_SEL_W-1:0]].tag;
            end
        end else if (use_d) begin
            result_o.hit     = d_hit;
            result_o.way     = d_way;
            result_o.changed = d_changed;
            if (evict) begin
                result_o.evict_tag = current_line_d_i[d_way[D_SEL_W-1:0]].tag;
            end
        end else begin
            result_o.changed = (instruction_i.n == cache_pkg::CLEAR);  // whole store wiped
        end
    end

endmodule

`default_nettype wire

/* hdl/trace_stage.sv */
// command register and result register with their strobes
`timescale 1ns/10ps
`default_nettype none

module trace_stage (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                cmd_valid_i,
    input  cache_pkg::command_t command_i,
    input  cache_pkg::result_t  result_i,
    output cache_pkg::command_t command_o,
    output logic                cmd_pending_o,
    output logic                result_valid_o,
    output cache_pkg::result_t  result_o
);

    // command stage, live for one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst_i) begin
            command_o     <= '0;
            cmd_pending_o <= 1'b0;
        end else begin
            cmd_pending_o <= cmd_valid_i;
            if (cmd_valid_i) begin
                command_o <= command_i;
            end
        end
    end

    // result stage, captured on the same edge the store is written
    always_ff @(posedge clk) begin
        if (rst_i) begin
            result_o       <= '0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= cmd_pending_o;  // single-cycle pulse per command
            if (cmd_pending_o) begin
                result_o <= result_i;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/cache_top.sv */
// top level of the split L1 cache model: stage, store and processor
`timescale 1ns/10ps
`default_nettype none

module cache_top #(
    parameter int D_WAYS = 8,
    parameter int I_WAYS = 4
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                cmd_valid_i,
    input  cache_pkg::command_t command_i,
    output logic                result_valid_o,
    output cache_pkg::result_t  result_o
);

    cache_pkg::command_t    command_q;
    cache_pkg::result_t     result_d;
    cache_pkg::cache_line_t d_lines_cur [D_WAYS];
    cache_pkg::cache_line_t i_lines_cur [I_WAYS];
    cache_pkg::cache_line_t d_lines_new [D_WAYS];
    cache_pkg::cache_line_t i_lines_new [I_WAYS];
    logic                   cmd_pending;
    logic                   d_we;
    logic                   i_we;
    logic                   clear;

    trace_stage u_stage (
        .clk            (clk),
        .rst_i          (rst_i),
        .cmd_valid_i    (cmd_valid_i),
        .command_i      (command_i),
        .result_i       (result_d),
        .command_o      (command_q),
        .cmd_pending_o  (cmd_pending),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    cache_set_store #(.D_WAYS(D_WAYS), .I_WAYS(I_WAYS)) u_store (
        .clk       (clk),
        .rst_i     (rst_i),
        .index_i   (command_q.address.index),
        .clear_i   (clear),
        .d_we_i    (d_we),
        .i_we_i    (i_we),
        .d_lines_i (d_lines_new),
        .i_lines_i (i_lines_new),
        .d_lines_o (d_lines_cur),
        .i_lines_o (i_lines_cur)
    );

    processor #(.D_WAYS(D_WAYS), .I_WAYS(I_WAYS)) u_proc (
        .instruction_i    (command_q),
        .cmd_pending_i    (cmd_pending),
        .current_line_d_i (d_lines_cur),
        .current_line_i_i (i_lines_cur),
        .return_line_d_o  (d_lines_new),
        .return_line_i_o  (i_lines_new),
        .d_we_o           (d_we),
        .i_we_o           (i_we),
        .clear_o          (clear),
        .result_o         (result_d)
    );

endmodule

`default_nettype wire

/* tests/cache_assert.sv */
// concurrent checks on the cache top-level strobe and result fields
`timescale 1ns/10ps
`default_nettype none

module cache_assert #(
    parameter int D_WAYS = 8,
    parameter int I_WAYS = 4
) (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               cmd_valid_i,
    input  logic               result_valid_i,
    input  cache_pkg::result_t result_i
);

    // command sampled at edge k gives its result strobe at edge k+1, seen at k+2
    a_strobe_follows_command: assert property (
        @(posedge clk) disable iff (rst_i)
        result_valid_i == $past(cmd_valid_i, 2)
    ) else $error("result strobe does not match the command strobe two cycles earlier");

    a_hit_not_evict: assert property (
        @(posedge clk) disable iff (rst_i)
        result_valid_i |-> !(result_i.hit && result_i.evict)
    ) else $error("result reports a hit and an eviction together");

    // way must exist in the cache that served the command
    a_way_in_range: assert property (
        @(posedge clk) disable iff (rst_i)
        result_valid_i |-> (int'(result_i.way) < (result_i.icache ? I_WAYS : D_WAYS))
    ) else $error("result way is outside the selected cache");

endmodule

`default_nettype wire

/* tests/cache_tb.sv */
// split L1 cache testbench: clock, reset, command table, result checks, timeout, report
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

    localparam int  RESET_CYCLES = 5;
    localparam time PERIOD       = 100ns;
    localparam time DRIVE_DELAY  = 5ns;

    // command codes as the trace defines them
    localparam logic [3:0] RD  = 4'd0;
    localparam logic [3:0] WR  = 4'd1;
    localparam logic [3:0] FE  = 4'd2;
    localparam logic [3:0] INV = 4'd3;
    localparam logic [3:0] SNP = 4'd4;
    localparam logic [3:0] UNK = 4'd5;  // undefined code, acts as a no-op
    localparam logic [3:0] CLR = 4'd8;
    localparam logic [3:0] NOP = 4'd9;

    typedef struct packed {
        logic [3:0]      code;
        logic [3:0]      index;
        cache_pkg::tag_t tag;
        logic            hit;
        cache_pkg::way_t way;
        logic            evict;
        cache_pkg::tag_t evict_tag;
    } vector_t;

    logic                clk;
    logic                rst_i;
    logic                cmd_valid_i;
    cache_pkg::command_t command_i;
    logic                result_valid_o;
    cache_pkg::result_t  result_o;

    vector_t table_q[$];
    int      cycles    = 0;
    int      checked   = 0;
    int      passed    = 0;
    int      errors    = 0;
    int      limit     = 0;
    logic    timed_out = 1'b0;

    cache_top #(.D_WAYS(8), .I_WAYS(4)) UUT (
        .clk            (clk),
        .rst_i          (rst_i),
        .cmd_valid_i    (cmd_valid_i),
        .command_i      (command_i),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

    bind cache_top cache_assert #(.D_WAYS(D_WAYS), .I_WAYS(I_WAYS)) u_assert (
        .clk            (clk),
        .rst_i          (rst_i),
        .cmd_valid_i    (cmd_valid_i),
        .result_valid_i (result_valid_o),
        .result_i       (result_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    task automatic add_vector(input logic [3:0] code, input logic [3:0] index,
                              input logic [21:0] tag, input logic hit, input int way,
                              input logic evict, input logic [21:0] etag);
        vector_t v;
        v.code      = code;
        v.index     = index;
        v.tag       = tag;
        v.hit       = hit;
        v.way       = cache_pkg::way_t'(way);
        v.evict     = evict;
        v.evict_tag = etag;
        table_q.push_back(v);
    endtask

    // expected outcomes worked out by hand from the LRU rules
    task automatic build_table();
        for (int w = 0; w < 8; w++) begin
            add_vector(RD, 4'd1, 22'h10 + 22'(w), 0, w, 0, 0);  // cold fill of set 1
        end
        add_vector(RD,  4'd1, 22'h13, 1, 3, 0, 0);
        add_vector(RD,  4'd1, 22'h18, 0, 0, 1, 22'h10);   // oldest is 0x10
        add_vector(RD,  4'd1, 22'h11, 1, 1, 0, 0);        // touch moves 0x11 to front
        add_vector(RD,  4'd1, 22'h19, 0, 2, 1, 22'h12);
        add_vector(WR,  4'd1, 22'h18, 1, 0, 0, 0);
        // set 2, data and instruction side by side
        add_vector(RD,  4'd2, 22'h20, 0, 0, 0, 0);
        add_vector(RD,  4'd2, 22'h21, 0, 1, 0, 0);
        add_vector(FE,  4'd2, 22'h30, 0, 0, 0, 0);
        add_vector(FE,  4'd2, 22'h31, 0, 1, 0, 0);
        add_vector(FE,  4'd2, 22'h32, 0, 2, 0, 0);
        add_vector(FE,  4'd2, 22'h33, 0, 3, 0, 0);
        add_vector(FE,  4'd2, 22'h34, 0, 0, 1, 22'h30);
        add_vector(FE,  4'd2, 22'h20, 0, 1, 1, 22'h31);   // data tag misses in icache
        add_vector(FE,  4'd2, 22'h32, 1, 2, 0, 0);
        add_vector(RD,  4'd2, 22'h20, 1, 0, 0, 0);
        add_vector(RD,  4'd2, 22'h21, 1, 1, 0, 0);
        add_vector(RD,  4'd2, 22'h30, 0, 2, 0, 0);
        // invalidate and snoop on set 1
        add_vector(INV, 4'd1, 22'h15, 1, 5, 0, 0);
        add_vector(RD,  4'd1, 22'h1a, 0, 5, 0, 0);        // takes the freed way
        add_vector(INV, 4'd1, 22'h3ff, 0, 4, 0, 0);
        add_vector(SNP, 4'd1, 22'h14, 1, 4, 0, 0);
        add_vector(SNP, 4'd1, 22'h3fe, 0, 4, 0, 0);
        add_vector(RD,  4'd1, 22'h1b, 0, 4, 1, 22'h14);
        // no-ops and clear
        add_vector(NOP, 4'd1, 22'h18, 0, 0, 0, 0);
        add_vector(UNK, 4'd1, 22'h18, 0, 0, 0, 0);
        add_vector(RD,  4'd1, 22'h18, 1, 0, 0, 0);
        add_vector(CLR, 4'd0, 22'h0,  0, 0, 0, 0);
        add_vector(RD,  4'd1, 22'h18, 0, 0, 0, 0);
        add_vector(RD,  4'd2, 22'h20, 0, 0, 0, 0);
        add_vector(FE,  4'd2, 22'h34, 0, 0, 0, 0);
        add_vector(RD,  4'd1, 22'h19, 0, 1, 0, 0);
        add_vector(INV, 4'd1, 22'h11, 0, 2, 0, 0);        // lowest invalid way
    endtask

    task automatic drive_command(input vector_t v, input int n);
        cache_pkg::command_t c;
        c.n              = cache_pkg::cmd_code_t'(v.code);
        c.address.tag    = v.tag;
        c.address.index  = v.index;
        c.address.offset = n[5:0] ^ 6'h2a;  // offset must not matter
        @(posedge clk);
        #(DRIVE_DELAY);
        command_i   = c;
        cmd_valid_i = 1'b1;
    endtask

    task automatic check_result(input vector_t v, input int n);
        int   bad;
        logic icache_exp;
        logic changed_exp;
        bad         = 0;
        icache_exp  = (v.code == FE);
        // fills, an invalidate hit and a clear rewrite the store
        changed_exp = (v.code == RD) || (v.code == WR) || (v.code == FE) ||
                      (v.code == CLR) || ((v.code == INV) && v.hit);
        if (result_o.code != v.code) begin
            $display("error: test %0d result_o.code got %h expected %h", n, result_o.code, v.code);
            bad++;
        end
        if (result_o.hit != v.hit) begin
            $display("error: test %0d result_o.hit got %h expected %h", n, result_o.hit, v.hit);
            bad++;
        end
        if (result_o.way != v.way) begin
            $display("error: test %0d result_o.way got %h expected %h", n, result_o.way, v.way);
            bad++;
        end
        if (result_o.evict != v.evict) begin
            $display("error: test %0d result_o.evict got %h expected %h",
                     n, result_o.evict, v.evict);
            bad++;
        end
        if (result_o.evict_tag != v.evict_tag) begin
            $display("error: test %0d result_o.evict_tag got %h expected %h",
                     n, result_o.evict_tag, v.evict_tag);
            bad++;
        end
        if (result_o.icache != icache_exp) begin
            $display("error: test %0d result_o.icache got %h expected %h",
                     n, result_o.icache, icache_exp);
            bad++;
        end
        if (result_o.changed != changed_exp) begin
            $display("error: test %0d result_o.changed got %h expected %h",
                     n, result_o.changed, changed_exp);
            bad++;
        end
        if (bad == 0) begin
            $display("test %0d code %0d set %0d tag %h ok", n, v.code, v.index, v.tag);
            passed++;
        end else begin
            $display("test %0d code %0d set %0d tag %h mismatch", n, v.code, v.index, v.tag);
            errors++;
        end
    endtask

    // results are read mid-cycle, away from the edges
    always @(negedge clk) begin
        if (result_valid_o) begin
            if (checked < table_q.size()) begin
                check_result(table_q[checked], checked);
            end else begin
                $display("unexpected result strobe after the last command");
                errors++;
            end
            checked++;
        end
    end

    initial begin
        rst_i       = 1'b1;
        cmd_valid_i = 1'b0;
        command_i   = '0;
        build_table();
        limit = table_q.size() + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_i = 1'b0;

        for (int n = 0; n < table_q.size(); n++) begin
            drive_command(table_q[n], n);
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        cmd_valid_i = 1'b0;
        command_i   = '0;

        while (checked < table_q.size() && cycles < limit) @(posedge clk);
        if (checked < table_q.size()) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d results arrived within %0d cycles",
                     checked, table_q.size(), limit);
        end
        repeat (3) @(posedge clk);  // catch stray strobes

        $display("summary: %0d tests, %0d ok, %0d with errors", table_q.size(), passed, errors);
        if (errors == 0 && !timed_out && passed == table_q.size()) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hdl/cache_pkg.sv
hdl/cache_set_store.sv
hdl/way_lookup.sv
hdl/lru_update.sv
hdl/processor.sv
hdl/trace_stage.sv
hdl/cache_top.sv
tests/cache_assert.sv
tests/cache_tb.sv

/* run.sh */
#!/bin/sh
# compile with Verilator, run, then look for the pass line in sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cache_tb -f build.f -o cache_sim \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/cache_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "all tests passed" sim.log && exit 0 || exit 1
